//--- verilog/pep_pkg.sv
// PBS processing element shared widths, key RAM map, opcodes and error flags
`default_nettype none

package pep_pkg;

  // ------------------------------------------------------------------------
  // Word and digit sizes
  // ------------------------------------------------------------------------
  localparam int Q_W = 16;
  localparam int B_W = 4;
  // Digits per operand
  localparam int LBY = Q_W / B_W;
  // Table index width, 16 entries
  localparam int N_W = 4;
  localparam int DST_W = 4;

  // ------------------------------------------------------------------------
  // Key RAM map
  // ------------------------------------------------------------------------
  localparam int KEY_ADDR_W = 6;
  localparam int KSK_BASE = 0;
  localparam int LUT_BASE = 32;

  typedef logic [Q_W-1:0] pep_word_t;
  typedef logic [DST_W-1:0] pep_dst_t;
  typedef logic [KEY_ADDR_W-1:0] key_addr_t;

  // Encoding 3 is left undefined and is rejected
  typedef enum logic [1:0] {
    OP_NOP = 2'd0,
    OP_KS  = 2'd1,
    OP_PBS = 2'd2
  } pbs_opcode_e;

  typedef struct packed {
    logic fifo_ovf;
    logic bad_op;
  } pep_error_t;

endpackage

`default_nettype wire

//--- verilog/key_mem_if.sv
// Key RAM read channel between one requester and the shared arbiter
`timescale 1ns/1ns
`default_nettype none

interface key_mem_if;

  // Held by the requester until gnt
  logic                 req;
  pep_pkg::key_addr_t   addr;
  // One-cycle grant, data one cycle later
  logic                 gnt;
  logic                 rvld;
  pep_pkg::pep_word_t   rdata;

  modport requester (
    output req, addr,
    input  gnt, rvld, rdata
  );

  modport arbiter (
    input  req, addr,
    output gnt, rvld, rdata
  );

endinterface

`default_nettype wire

//--- verilog/pep_op_if.sv
// Operation hand-off between pipeline stages with receiver-driven busy
`timescale 1ns/1ns
`default_nettype none

interface pep_op_if;

  // Single-cycle strobe, only while busy is low
  logic                  vld;
  pep_pkg::pbs_opcode_e  op;
  pep_pkg::pep_dst_t     dst_id;
  pep_pkg::pep_word_t    value;
  // Receiver occupied
  logic                  busy;

  modport src (
    output vld, op, dst_id, value,
    input  busy
  );

  modport dst (
    input  vld, op, dst_id, value,
    output busy
  );

endinterface

`default_nettype wire

//--- verilog/key_ram_arbiter.sv
// Key RAM with write port and a round-robin shared registered read port
`timescale 1ns/1ns
`default_nettype none

module key_ram_arbiter (
  input  logic                clk,
  input  logic                s_rst_n,

  input  logic                key_wr_en,
  input  pep_pkg::key_addr_t  key_wr_addr,
  input  pep_pkg::pep_word_t  key_wr_data,

  key_mem_if.arbiter          ks_port,
  key_mem_if.arbiter          lut_port
);

  localparam int KEY_WORDS = 1 << pep_pkg::KEY_ADDR_W;

  pep_pkg::pep_word_t  key_mem [KEY_WORDS];
  pep_pkg::pep_word_t  rd_data_q;
  pep_pkg::key_addr_t  rd_addr;

  logic ks_gnt;
  logic lut_gnt;
  logic ks_rvld_q;
  logic lut_rvld_q;
  // Set when the lookup unit won last, so the key switch wins the next tie
  logic last_lut_q;

  // ------------------------------------------------------------------------
  // Grant
  // ------------------------------------------------------------------------
  always_comb begin
    if (ks_port.req && lut_port.req) begin
      ks_gnt  = last_lut_q;
      lut_gnt = !last_lut_q;
    end else begin
      ks_gnt  = ks_port.req;
      lut_gnt = lut_port.req;
    end
  end

  assign rd_addr = lut_gnt ? lut_port.addr : ks_port.addr;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      last_lut_q <= 1'b1;
      ks_rvld_q  <= 1'b0;
      lut_rvld_q <= 1'b0;
    end else begin
      ks_rvld_q  <= ks_gnt;
      lut_rvld_q <= lut_gnt;
      if (ks_gnt) begin
        last_lut_q <= 1'b0;
      end else if (lut_gnt) begin
        last_lut_q <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (key_wr_en) begin
      key_mem[key_wr_addr] <= key_wr_data;
    end
  end

  // Read on grant, so rdata lines up with rvld
  always_ff @(posedge clk) begin
    if (ks_gnt || lut_gnt) begin
      rd_data_q <= key_mem[rd_addr];
    end
  end

  assign ks_port.gnt    = ks_gnt;
  assign ks_port.rvld   = ks_rvld_q;
  assign ks_port.rdata  = rd_data_q;
  assign lut_port.gnt   = lut_gnt;
  assign lut_port.rvld  = lut_rvld_q;
  assign lut_port.rdata = rd_data_q;

endmodule

`default_nettype wire

//--- verilog/pep_sequencer.sv
// Instruction sequencer with opcode check, FIFO, dispatch and error flags
`timescale 1ns/1ns
`default_nettype none

module pep_sequencer #(
  parameter int INST_FIFO_DEPTH = 8
) (
  input  logic                  clk,
  input  logic                  s_rst_n,

  input  logic                  inst_vld,
  input  pep_pkg::pbs_opcode_e  inst_op,
  input  pep_pkg::pep_dst_t     inst_dst,
  input  pep_pkg::pep_word_t    inst_operand,

  pep_op_if.src                 cmd,

  output pep_pkg::pep_error_t   error
);

  localparam int PTR_W = $clog2(INST_FIFO_DEPTH);
  localparam int CNT_W = $clog2(INST_FIFO_DEPTH + 1);

  pep_pkg::pbs_opcode_e  fifo_op  [INST_FIFO_DEPTH];
  pep_pkg::pep_dst_t     fifo_dst [INST_FIFO_DEPTH];
  pep_pkg::pep_word_t    fifo_val [INST_FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic op_ok;
  logic op_bad;
  logic full;
  logic empty;
  logic fifo_wr;
  logic fifo_rd;
  logic vld_q;

  // ------------------------------------------------------------------------
  // Strobe check
  // ------------------------------------------------------------------------
  always_comb begin
    op_ok  = 1'b0;
    op_bad = 1'b0;
    if (inst_vld) begin
      case (inst_op)
        pep_pkg::OP_KS,
        pep_pkg::OP_PBS: op_ok = 1'b1;
        // NOP is dropped without a flag
        pep_pkg::OP_NOP: op_ok = 1'b0;
        default:         op_bad = 1'b1;
      endcase
    end
  end

  assign full    = (count_q == CNT_W'(INST_FIFO_DEPTH));
  assign empty   = (count_q == '0);
  assign fifo_wr = op_ok && !full;
  // Hold off one cycle after a pulse until busy has risen
  assign fifo_rd = !cmd.busy && !empty && !vld_q;

  always_ff @(posedge clk) begin
    if (fifo_wr) begin
      fifo_op[wr_ptr_q]  <= inst_op;
      fifo_dst[wr_ptr_q] <= inst_dst;
      fifo_val[wr_ptr_q] <= inst_operand;
    end
    if (fifo_rd) begin
      cmd.op     <= fifo_op[rd_ptr_q];
      cmd.dst_id <= fifo_dst[rd_ptr_q];
      cmd.value  <= fifo_val[rd_ptr_q];
    end
  end

  // ------------------------------------------------------------------------
  // Pointers, dispatch strobe and error flags
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      vld_q    <= 1'b0;
      error    <= '0;
    end else begin
      if (fifo_wr) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(INST_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (fifo_rd) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(INST_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q        <= count_q + CNT_W'(fifo_wr) - CNT_W'(fifo_rd);
      vld_q          <= fifo_rd;
      error.fifo_ovf <= op_ok && full;
      error.bad_op   <= op_bad;
    end
  end

  assign cmd.vld = vld_q;

endmodule

`default_nettype wire

//--- verilog/pep_key_switch.sv
// Key switch: digit decomposition and accumulation against KSK words
`timescale 1ns/1ns
`default_nettype none

module pep_key_switch (
  input  logic         clk,
  input  logic         s_rst_n,

  pep_op_if.dst        cmd_in,
  pep_op_if.src        cmd_out,

  key_mem_if.requester ksk_mem
);

  localparam int DIG_W = $clog2(pep_pkg::LBY);

  typedef enum logic [1:0] {
    KS_IDLE,
    KS_READ,
    KS_WAIT_DATA,
    KS_HANDOFF
  } ks_state_e;

  ks_state_e             state_q;
  pep_pkg::pbs_opcode_e  op_q;
  pep_pkg::pep_dst_t     dst_q;
  pep_pkg::pep_word_t    operand_q;
  pep_pkg::pep_word_t    acc_q;
  logic [DIG_W-1:0]      digit_q;
  logic [pep_pkg::B_W-1:0] cur_digit;
  logic                  accept;
  logic                  last_digit;
  logic                  handoff;

  assign accept     = (state_q == KS_IDLE) && cmd_in.vld;
  assign last_digit = (digit_q == DIG_W'(pep_pkg::LBY - 1));
  assign handoff    = (state_q == KS_HANDOFF) && !cmd_out.busy;
  // Digit j, least significant first
  assign cur_digit  = operand_q[digit_q*pep_pkg::B_W +: pep_pkg::B_W];

  // Free again in the hand-off cycle
  assign cmd_in.busy = (state_q != KS_IDLE) && !handoff;

  assign ksk_mem.req  = (state_q == KS_READ);
  assign ksk_mem.addr = pep_pkg::key_addr_t'(pep_pkg::KSK_BASE)
                      + pep_pkg::key_addr_t'(digit_q);

  // ------------------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      state_q <= KS_IDLE;
      digit_q <= '0;
    end else begin
      case (state_q)
        KS_IDLE: begin
          if (cmd_in.vld) begin
            state_q <= KS_READ;
            digit_q <= '0;
          end
        end
        KS_READ: if (ksk_mem.gnt) state_q <= KS_WAIT_DATA;
        KS_WAIT_DATA: begin
          if (ksk_mem.rvld) begin
            state_q <= last_digit ? KS_HANDOFF : KS_READ;
            digit_q <= digit_q + 1'b1;
          end
        end
        default: if (handoff) state_q <= KS_IDLE;
      endcase
    end
  end

  // Operand, tag and running sum mod 2^Q_W
  always_ff @(posedge clk) begin
    if (accept) begin
      operand_q <= cmd_in.value;
      op_q      <= cmd_in.op;
      dst_q     <= cmd_in.dst_id;
      acc_q     <= '0;
    end else if (state_q == KS_WAIT_DATA && ksk_mem.rvld) begin
      acc_q <= acc_q + cur_digit * ksk_mem.rdata;
    end
  end

  assign cmd_out.vld    = handoff;
  assign cmd_out.op     = op_q;
  assign cmd_out.dst_id = dst_q;
  assign cmd_out.value  = acc_q;

endmodule

`default_nettype wire

//--- verilog/pep_lut_rotate.sv
// Mod switch to a table index, bootstrap table lookup and result output
`timescale 1ns/1ns
`default_nettype none

module pep_lut_rotate (
  input  logic                clk,
  input  logic                s_rst_n,

  pep_op_if.dst               cmd_in,
  key_mem_if.requester        lut_mem,

  output logic                res_vld,
  output pep_pkg::pep_dst_t   res_dst,
  output pep_pkg::pep_word_t  res_data
);

  localparam int ROUND_BIT = pep_pkg::Q_W - pep_pkg::N_W - 1;

  typedef enum logic [1:0] {
    LUT_IDLE,
    LUT_READ,
    LUT_WAIT_DATA,
    LUT_RESULT
  } lut_state_e;

  lut_state_e            state_q;
  pep_pkg::pep_dst_t     dst_q;
  // Key-switched value, then the table word for PBS
  pep_pkg::pep_word_t    data_q;
  pep_pkg::pep_word_t    rounded;
  logic [pep_pkg::N_W-1:0] lut_idx;

  // Round to nearest, top bits wrap mod 2^N_W
  assign rounded = data_q + (pep_pkg::pep_word_t'(1) << ROUND_BIT);
  assign lut_idx = rounded[pep_pkg::Q_W-1 -: pep_pkg::N_W];

  assign lut_mem.req  = (state_q == LUT_READ);
  assign lut_mem.addr = pep_pkg::key_addr_t'(pep_pkg::LUT_BASE)
                      + pep_pkg::key_addr_t'(lut_idx);

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      state_q <= LUT_IDLE;
    end else begin
      case (state_q)
        LUT_IDLE: begin
          if (cmd_in.vld) begin
            state_q <= (cmd_in.op == pep_pkg::OP_PBS) ? LUT_READ : LUT_RESULT;
          end
        end
        LUT_READ:      if (lut_mem.gnt) state_q <= LUT_WAIT_DATA;
        LUT_WAIT_DATA: if (lut_mem.rvld) state_q <= LUT_RESULT;
        default:       state_q <= LUT_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == LUT_IDLE && cmd_in.vld) begin
      data_q <= cmd_in.value;
      dst_q  <= cmd_in.dst_id;
    end else if (state_q == LUT_WAIT_DATA && lut_mem.rvld) begin
      data_q <= lut_mem.rdata;
    end
  end

  assign cmd_in.busy = (state_q != LUT_IDLE);
  assign res_vld     = (state_q == LUT_RESULT);
  assign res_dst     = dst_q;
  assign res_data    = data_q;

endmodule

`default_nettype wire

//--- verilog/pep_core.sv
// PBS processing element top: sequencer, key switch, lookup unit and key RAM
`timescale 1ns/1ns
`default_nettype none

module pep_core #(
  parameter int INST_FIFO_DEPTH = 8
) (
  input  logic                  clk,
  input  logic                  s_rst_n,

  // Instruction strobe
  input  logic                  inst_vld,
  input  pep_pkg::pbs_opcode_e  inst_op,
  input  pep_pkg::pep_dst_t     inst_dst,
  input  pep_pkg::pep_word_t    inst_operand,

  // Key RAM load
  input  logic                  key_wr_en,
  input  pep_pkg::key_addr_t    key_wr_addr,
  input  pep_pkg::pep_word_t    key_wr_data,

  // Results in issue order
  output logic                  res_vld,
  output pep_pkg::pep_dst_t     res_dst,
  output pep_pkg::pep_word_t    res_data,

  output pep_pkg::pep_error_t   error
);

  pep_op_if  seq_ks ();
  pep_op_if  ks_lut ();
  key_mem_if ks_mem ();
  key_mem_if lut_mem ();

  // ------------------------------------------------------------------------
  // Pipeline stages
  // ------------------------------------------------------------------------
  pep_sequencer #(
    .INST_FIFO_DEPTH (INST_FIFO_DEPTH)
  ) pep_sequencer_i (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .inst_vld     (inst_vld),
    .inst_op      (inst_op),
    .inst_dst     (inst_dst),
    .inst_operand (inst_operand),
    .cmd          (seq_ks.src),
    .error        (error)
  );

  pep_key_switch pep_key_switch_i (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .cmd_in  (seq_ks.dst),
    .cmd_out (ks_lut.src),
    .ksk_mem (ks_mem.requester)
  );

  pep_lut_rotate pep_lut_rotate_i (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .cmd_in   (ks_lut.dst),
    .lut_mem  (lut_mem.requester),
    .res_vld  (res_vld),
    .res_dst  (res_dst),
    .res_data (res_data)
  );

  // Shared key RAM
  key_ram_arbiter key_ram_arbiter_i (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .key_wr_en   (key_wr_en),
    .key_wr_addr (key_wr_addr),
    .key_wr_data (key_wr_data),
    .ks_port     (ks_mem.arbiter),
    .lut_port    (lut_mem.arbiter)
  );

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
// Testbench clock and synchronous reset generator
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic s_rst_n
);

  localparam int HALF_PERIOD_NS = 5;
  localparam int RESET_CYCLES = 2;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  // Held low over two rising edges, released on a falling edge
  initial begin
    s_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    s_rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- dv/pep_core_assertions.sv
// Concurrent checks on the key RAM grant and read-return protocol
`timescale 1ns/1ns
`default_nettype none

module pep_core_assertions (
  input logic clk,
  input logic s_rst_n,
  input logic ks_req,
  input logic lut_req,
  input logic ks_gnt,
  input logic lut_gnt,
  input logic ks_rvld,
  input logic lut_rvld
);

  // ------------------------------------------------------------------------
  // Grant
  // ------------------------------------------------------------------------
  one_grant_a: assert property (@(posedge clk) disable iff (!s_rst_n)
    !(ks_gnt && lut_gnt))
    else $error("Both key RAM grants high in one cycle");

  ks_gnt_req_a: assert property (@(posedge clk) disable iff (!s_rst_n)
    ks_gnt |-> ks_req)
    else $error("Key switch granted without a request");

  lut_gnt_req_a: assert property (@(posedge clk) disable iff (!s_rst_n)
    lut_gnt |-> lut_req)
    else $error("Lookup unit granted without a request");

  // ------------------------------------------------------------------------
  // Read return
  // ------------------------------------------------------------------------
  ks_rvld_a: assert property (@(posedge clk) disable iff (!s_rst_n)
    ks_gnt |=> ks_rvld)
    else $error("Key switch read data missing one cycle after grant");

  lut_rvld_a: assert property (@(posedge clk) disable iff (!s_rst_n)
    lut_gnt |=> lut_rvld)
    else $error("Lookup unit read data missing one cycle after grant");

  // Reset is synchronous, so rvld is low from the cycle after it is seen
  rst_rvld_a: assert property (@(posedge clk)
    !s_rst_n |=> !(ks_rvld || lut_rvld))
    else $error("Key RAM read valid during reset");

endmodule

`default_nettype wire

//--- dv/pep_core_tb.sv
// Testbench for the PBS processing element with table-driven stimulus
`timescale 1ns/1ns
`default_nettype none

module pep_core_tb;

  localparam int FIFO_DEPTH = 8;
  localparam int SEED = 69663;
  localparam int RESET_TIMEOUT = 20;
  localparam int DRAIN_TIMEOUT = 400;
  localparam int QUIET_CYCLES = 4;
  localparam int KEY_WORDS = 1 << pep_pkg::KEY_ADDR_W;

  typedef struct {
    logic [1:0]          op;
    pep_pkg::pep_dst_t   dst;
    pep_pkg::pep_word_t  operand;
    // Identity KSK, so the operand reaches the table unchanged
    logic                ident_ksk;
    // Next row is strobed in the following cycle
    logic                burst;
    logic                ovf_ok;
    pep_pkg::pep_error_t exp_err;
  } stim_row_t;

  typedef struct {
    pep_pkg::pep_dst_t  dst;
    pep_pkg::pep_word_t data;
  } exp_res_t;

  logic                 clk;
  logic                 s_rst_n;
  logic                 inst_vld;
  pep_pkg::pbs_opcode_e inst_op;
  pep_pkg::pep_dst_t    inst_dst;
  pep_pkg::pep_word_t   inst_operand;
  logic                 key_wr_en;
  pep_pkg::key_addr_t   key_wr_addr;
  pep_pkg::pep_word_t   key_wr_data;
  logic                 res_vld;
  pep_pkg::pep_dst_t    res_dst;
  pep_pkg::pep_word_t   res_data;
  pep_pkg::pep_error_t  error;

  stim_row_t          rows[$];
  exp_res_t           exp_q[$];
  pep_pkg::pep_word_t key_mirror [KEY_WORDS];
  logic               ident_q;
  int err_cnt = 0;
  int timeout_cnt = 0;
  int result_cnt = 0;
  int ovf_cnt = 0;
  int valid_cnt = 0;
  int ovf_rows = 0;

  tb_clk_gen tb_clk_gen_i (
    .clk     (clk),
    .s_rst_n (s_rst_n)
  );

  pep_core #(
    .INST_FIFO_DEPTH (FIFO_DEPTH)
  ) pep_core_i (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .inst_vld     (inst_vld),
    .inst_op      (inst_op),
    .inst_dst     (inst_dst),
    .inst_operand (inst_operand),
    .key_wr_en    (key_wr_en),
    .key_wr_addr  (key_wr_addr),
    .key_wr_data  (key_wr_data),
    .res_vld      (res_vld),
    .res_dst      (res_dst),
    .res_data     (res_data),
    .error        (error)
  );

  bind key_ram_arbiter pep_core_assertions pep_core_assertions_i (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .ks_req   (ks_port.req),
    .lut_req  (lut_port.req),
    .ks_gnt   (ks_gnt),
    .lut_gnt  (lut_gnt),
    .ks_rvld  (ks_rvld_q),
    .lut_rvld (lut_rvld_q)
  );

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------
  // Sum of digit times KSK word, mod 2^Q_W
  function automatic pep_pkg::pep_word_t ks_model(input pep_pkg::pep_word_t operand);
    int sum;
    int digit;
    sum = 0;
    for (int j = 0; j < pep_pkg::LBY; j++) begin
      digit = (int'(operand) >> (pep_pkg::B_W * j)) % (1 << pep_pkg::B_W);
      sum = (sum + digit * int'(key_mirror[pep_pkg::KSK_BASE + j])) % (1 << pep_pkg::Q_W);
    end
    return pep_pkg::pep_word_t'(sum);
  endfunction

  // Round to nearest table index, wrapping at the top
  function automatic pep_pkg::pep_word_t pbs_model(input pep_pkg::pep_word_t value);
    int idx;
    idx = (int'(value) + (1 << (pep_pkg::Q_W - pep_pkg::N_W - 1))) >> (pep_pkg::Q_W - pep_pkg::N_W);
    idx = idx % (1 << pep_pkg::N_W);
    return key_mirror[pep_pkg::LUT_BASE + idx];
  endfunction

  function automatic pep_pkg::pep_word_t expected_value(input logic [1:0] op,
                                                        input pep_pkg::pep_word_t operand);
    pep_pkg::pep_word_t ks;
    ks = ks_model(operand);
    return (op == pep_pkg::OP_PBS) ? pbs_model(ks) : ks;
  endfunction

  // ------------------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------------------
  task automatic check_result(input pep_pkg::pep_dst_t got_dst, input pep_pkg::pep_word_t got_data,
                              input pep_pkg::pep_dst_t exp_dst, input pep_pkg::pep_word_t exp_data);
    if (got_dst !== exp_dst || got_data !== exp_data) begin
      err_cnt++;
      $display("ERR @%0t: result dst %0d data 0x%04h, expected dst %0d data 0x%04h",
               $time, got_dst, got_data, exp_dst, exp_data);
    end
  endtask

  task automatic check_error(input pep_pkg::pep_error_t got, input pep_pkg::pep_error_t exp,
                             input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR @%0t: %s error flags %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR @%0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // In-order result monitor
  always @(negedge clk) begin : result_monitor
    exp_res_t want;
    if (s_rst_n === 1'b1 && res_vld === 1'b1) begin
      result_cnt++;
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("ERR @%0t: unexpected result dst %0d data 0x%04h", $time, res_dst, res_data);
      end else begin
        want = exp_q.pop_front();
        check_result(res_dst, res_data, want.dst, want.data);
      end
    end
  end

  // ------------------------------------------------------------------------
  // Stimulus helpers, all called on a falling edge
  // ------------------------------------------------------------------------
  task automatic write_key(input pep_pkg::key_addr_t addr, input pep_pkg::pep_word_t data);
    key_wr_en   = 1'b1;
    key_wr_addr = addr;
    key_wr_data = data;
    key_mirror[addr] = data;
    @(negedge clk);
    key_wr_en = 1'b0;
    check_flag(res_vld, 1'b0, "res_vld while loading keys");
    check_error(error, '0, "key load");
  endtask

  task automatic load_ksk(input logic ident);
    pep_pkg::pep_word_t word;
    for (int j = 0; j < pep_pkg::LBY; j++) begin
      word = ident ? pep_pkg::pep_word_t'(1 << (pep_pkg::B_W * j))
                   : pep_pkg::pep_word_t'($urandom);
      write_key(pep_pkg::key_addr_t'(pep_pkg::KSK_BASE + j), word);
    end
  endtask

  // Wait for all outstanding results, then a quiet spell with no flags
  task automatic drain();
    int cycles;
    inst_vld = 1'b0;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
      @(negedge clk);
      check_error(error, '0, "idle");
      cycles++;
    end
    if (exp_q.size() != 0) begin
      timeout_cnt++;
      $display("Timeout: %0d results still missing after %0d cycles", exp_q.size(), cycles);
      exp_q.delete();
    end
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      check_error(error, '0, "idle");
    end
  endtask

  task automatic apply_row(input stim_row_t row);
    pep_pkg::pep_error_t exp_err;
    exp_res_t            res;
    inst_vld     = 1'b1;
    inst_op      = pep_pkg::pbs_opcode_e'(row.op);
    inst_dst     = row.dst;
    inst_operand = row.operand;
    @(negedge clk);
    exp_err = row.exp_err;
    // Whether a strobe in the overflow burst fits depends on the FIFO fill
    if (row.ovf_ok) exp_err.fifo_ovf = error.fifo_ovf;
    check_error(error, exp_err, "strobe");
    if (error.fifo_ovf === 1'b1) ovf_cnt++;
    if (row.op == pep_pkg::OP_KS || row.op == pep_pkg::OP_PBS) begin
      valid_cnt++;
      if (error.fifo_ovf !== 1'b1) begin
        res.dst  = row.dst;
        res.data = expected_value(row.op, row.operand);
        exp_q.push_back(res);
      end
    end
    if (!row.burst) drain();
  endtask

  task automatic add_row(input logic [1:0] op, input int dst, input int operand,
                         input logic ident, input logic burst, input logic ovf_ok,
                         input logic bad_op);
    stim_row_t row;
    row.op               = op;
    row.dst              = pep_pkg::pep_dst_t'(dst);
    row.operand          = pep_pkg::pep_word_t'(operand);
    row.ident_ksk        = ident;
    row.burst            = burst;
    row.ovf_ok           = ovf_ok;
    row.exp_err.fifo_ovf = 1'b0;
    row.exp_err.bad_op   = bad_op;
    if (ovf_ok) ovf_rows++;
    rows.push_back(row);
  endtask

  // ------------------------------------------------------------------------
  // Stimulus table
  // ------------------------------------------------------------------------
  task automatic build_table();
    // Single instructions on random keys
    add_row(pep_pkg::OP_KS,  1, 16'h0000, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(pep_pkg::OP_KS,  2, 16'hFFFF, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(pep_pkg::OP_KS,  3, 16'h1234, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(pep_pkg::OP_PBS, 4, 16'h0F0F, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(pep_pkg::OP_PBS, 5, 16'h8001, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(pep_pkg::OP_NOP, 6, 16'h5555, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(2'd3,            7, 16'h1111, 1'b0, 1'b0, 1'b0, 1'b1);
    add_row(pep_pkg::OP_KS,  8, 16'h00FF, 1'b0, 1'b0, 1'b0, 1'b0);
    // Mixed back-to-back burst, shorter than the FIFO
    add_row(pep_pkg::OP_KS,  10, 16'h3C5A, 1'b0, 1'b1, 1'b0, 1'b0);
    add_row(pep_pkg::OP_PBS, 11, 16'hA5C3, 1'b0, 1'b1, 1'b0, 1'b0);
    add_row(pep_pkg::OP_PBS, 12, 16'h7E81, 1'b0, 1'b1, 1'b0, 1'b0);
    add_row(pep_pkg::OP_KS,  13, 16'hFFFF, 1'b0, 1'b1, 1'b0, 1'b0);
    add_row(pep_pkg::OP_PBS, 14, 16'h0001, 1'b0, 1'b1, 1'b0, 1'b0);
    add_row(pep_pkg::OP_KS,  15, 16'h4321, 1'b0, 1'b0, 1'b0, 1'b0);
    // Rounding boundaries and top wrap, identity key
    add_row(pep_pkg::OP_PBS, 0, 16'h07FF, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(pep_pkg::OP_PBS, 1, 16'h0800, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(pep_pkg::OP_PBS, 2, 16'hF7FF, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(pep_pkg::OP_PBS, 3, 16'hF800, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(pep_pkg::OP_PBS, 4, 16'hFFFF, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(pep_pkg::OP_KS,  5, 16'hBEEF, 1'b1, 1'b0, 1'b0, 1'b0);
    // Overflow burst on fresh random keys
    // The FIFO starts empty, so the first FIFO_DEPTH strobes always fit
    for (int i = 0; i < FIFO_DEPTH + 4; i++) begin
      add_row((i % 2 == 1) ? pep_pkg::OP_PBS : pep_pkg::OP_KS, i, int'($urandom),
              1'b0, (i < FIFO_DEPTH + 3), (i >= FIFO_DEPTH), 1'b0);
    end
  endtask

  // ------------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------------
  initial begin
    int cycles;
    inst_vld     = 1'b0;
    inst_op      = pep_pkg::OP_NOP;
    inst_dst     = '0;
    inst_operand = '0;
    key_wr_en    = 1'b0;
    key_wr_addr  = '0;
    key_wr_data  = '0;
    ident_q      = 1'b0;
    void'($urandom(SEED));
    build_table();

    cycles = 0;
    do begin
      @(negedge clk);
      check_flag(res_vld, 1'b0, "res_vld in reset");
      check_error(error, '0, "reset");
      cycles++;
    end while (s_rst_n !== 1'b1 && cycles < RESET_TIMEOUT);
    if (s_rst_n !== 1'b1) begin
      timeout_cnt++;
      $display("Timeout: reset was never released");
    end

    for (int a = 0; a < KEY_WORDS; a++) begin
      write_key(pep_pkg::key_addr_t'(a), pep_pkg::pep_word_t'($urandom));
    end

    foreach (rows[i]) begin
      if (rows[i].ident_ksk !== ident_q) begin
        load_ksk(rows[i].ident_ksk);
        ident_q = rows[i].ident_ksk;
      end
      apply_row(rows[i]);
    end
    drain();

    if (ovf_rows > 0 && ovf_cnt == 0) begin
      err_cnt++;
      $display("ERR @%0t: no fifo_ovf in %0d strobes beyond the FIFO depth", $time, ovf_rows);
    end
    if (result_cnt + ovf_cnt != valid_cnt) begin
      err_cnt++;
      $display("ERR @%0t: %0d results plus %0d drops, expected %0d strobes",
               $time, result_cnt, ovf_cnt, valid_cnt);
    end

    $display("Summary: %0d errors, %0d timeouts, %0d results, %0d dropped on full FIFO",
             err_cnt, timeout_cnt, result_cnt, ovf_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
verilog/pep_pkg.sv
verilog/key_mem_if.sv
verilog/pep_op_if.sv
verilog/key_ram_arbiter.sv
verilog/pep_sequencer.sv
verilog/pep_key_switch.sv
verilog/pep_lut_rotate.sv
verilog/pep_core.sv
dv/tb_clk_gen.sv
dv/pep_core_assertions.sv
dv/pep_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the PBS processing element testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=pep_core_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f \
  --top-module pep_core_tb \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qxF "Done: no errors" "$LOG_FILE"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
